// ==== common/gfx_pkg.sv ====
// --------------------------------------------------------------------------
// Shared geometry, CPU register map, configuration and colour types.
// The tile map is fixed at 8x8 tiles of 8x8 pixels, so map coordinates
// are always 6 bits and wrap modulo 64.
// ROM word address is {tile code, tile row, half}.
// --------------------------------------------------------------------------
`default_nettype none

package gfx_pkg;

    // Default raster geometry, one pixel per clock
    localparam int h_active = 64;
    localparam int h_total  = 256;
    localparam int v_active = 48;
    localparam int v_total  = 56;

    localparam int map_tiles = 8;
    localparam int rom_aw    = 12;

    // Register addresses with bit 7 clear; bit 7 set selects tile RAM
    typedef enum logic [7:0] {
        reg_scroll_x = 8'd0,
        reg_scroll_y = 8'd1,
        reg_ctrl     = 8'd2,
        reg_irq_ack  = 8'd3
    } reg_addr_t;

    typedef struct packed {
        logic [5:0] scroll_x;
        logic [5:0] scroll_y;
        logic       chr_en;
        logic       scr_en;
        logic       irq_en;
        logic [1:0] pal_bank;
    } gfx_cfg_t;

    // Layer flag is 1 for the scroll layer
    typedef struct packed {
        logic       layer;
        logic [1:0] pal_bank;
        logic [3:0] nibble;
    } pxl_color_t;

    typedef enum logic [2:0] {idle, code_rd, rom_req, rom_wait, next} fetch_state_t;

endpackage

`default_nettype wire

// ==== common/line_wr_if.sv ====
// --------------------------------------------------------------------------
// Line buffer write path. One write carries four pixels of one layer.
// x is the map column of the leftmost pixel and is 4-aligned.
// The target bank is not carried here.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface line_wr_if;

    logic        we;
    // 0 chr, 1 scr
    logic        layer;
    logic [5:0]  x;
    // Leftmost pixel in bits 15..12
    logic [15:0] pix;

    modport fetch (
        output we, layer, x, pix
    );

    modport buffer (
        input we, layer, x, pix
    );

endinterface

`default_nettype wire

// ==== design/gfx_cpu_port.sv ====
// --------------------------------------------------------------------------
// CPU write port. No read-back. Writes to unused register addresses
// are dropped. Tile RAM read has one cycle of latency.
// irq_n stays low until written at the acknowledge address.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gfx_cpu_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_cs,
    input  logic              cpu_we,
    input  logic [7:0]        cpu_addr,
    input  logic [7:0]        cpu_din,
    input  logic              vblank_start,
    input  logic [6:0]        tile_rd_addr,
    output gfx_pkg::gfx_cfg_t cfg,
    output logic [7:0]        tile_code,
    output logic              irq_n
);

    logic       wr_en;
    logic [7:0] tile_ram [0:127];

    assign wr_en = cpu_cs && cpu_we;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg   <= '0;
            irq_n <= 1'b1;
        end else begin
            if (wr_en && !cpu_addr[7]) begin
                case (gfx_pkg::reg_addr_t'(cpu_addr))
                    gfx_pkg::reg_scroll_x: cfg.scroll_x <= cpu_din[5:0];
                    gfx_pkg::reg_scroll_y: cfg.scroll_y <= cpu_din[5:0];
                    gfx_pkg::reg_ctrl: begin
                        cfg.chr_en   <= cpu_din[0];
                        cfg.scr_en   <= cpu_din[1];
                        cfg.irq_en   <= cpu_din[2];
                        cfg.pal_bank <= cpu_din[5:4];
                    end
                    gfx_pkg::reg_irq_ack: irq_n <= 1'b1;
                    default: ;
                endcase
            end
            // A new vblank wins over an acknowledge in the same cycle
            if (vblank_start && cfg.irq_en) begin
                irq_n <= 1'b0;
            end
        end
    end

    // Bit 6 picks the layer, bits 5..0 the tile index
    always_ff @(posedge clk) begin
        if (wr_en && cpu_addr[7]) begin
            tile_ram[cpu_addr[6:0]] <= cpu_din;
        end
        tile_code <= tile_ram[tile_rd_addr];
    end

    a_irq_source: assert property (@(posedge clk) disable iff (rst)
        $fell(irq_n) |-> $past(vblank_start))
        else $error("irq_n fell without a vblank_start pulse");

endmodule

`default_nettype wire

// ==== design/scan_timer.sv ====
// --------------------------------------------------------------------------
// Raster counters. Both start at 0, inside an active line.
// Assumes h_active < h_total and v_active < v_total.
// fetch_start marks hcount 0 of the line before each active line.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scan_timer #(
    parameter int h_active = gfx_pkg::h_active,
    parameter int h_total  = gfx_pkg::h_total,
    parameter int v_active = gfx_pkg::v_active,
    parameter int v_total  = gfx_pkg::v_total
) (
    input  logic                       clk,
    input  logic                       rst,
    output logic [$clog2(h_total)-1:0] hcount,
    output logic [$clog2(v_total)-1:0] vcount,
    output logic                       active,
    output logic                       fetch_start,
    output logic [5:0]                 fetch_line,
    output logic                       vblank,
    output logic                       vblank_start
);

    localparam int hw = $clog2(h_total);
    localparam int vw = $clog2(v_total);
    localparam logic [hw-1:0] h_last = hw'(h_total - 1);
    localparam logic [hw-1:0] h_act  = hw'(h_active);
    localparam logic [vw-1:0] v_last = vw'(v_total - 1);
    localparam logic [vw-1:0] v_act  = vw'(v_active);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == h_last) begin
            hcount <= '0;
            vcount <= (vcount == v_last) ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    assign active       = (hcount < h_act) && (vcount < v_act);
    assign vblank       = vcount >= v_act;
    assign vblank_start = (hcount == '0) && (vcount == v_act);

    // Next line is active when this one is not the last active line,
    // or when this is the final blank line of the frame
    assign fetch_start = (hcount == '0) && ((vcount < v_act - 1'b1) || (vcount == v_last));
    assign fetch_line  = (vcount == v_last) ? 6'd0 : 6'(vcount + 1'b1);

    a_fetch_pulse: assert property (@(posedge clk) disable iff (rst)
        fetch_start |=> !fetch_start)
        else $error("fetch_start held longer than one cycle");

    // The blank pulse sits on the first cycle of vblank only
    a_vblank_pulse: assert property (@(posedge clk) disable iff (rst)
        vblank_start |-> $rose(vblank))
        else $error("vblank_start not on the rising edge of vblank");

endmodule

`default_nettype wire

// ==== tilemap/tile_fetch.sv ====
// --------------------------------------------------------------------------
// Fetches one line of both layers, chr first, then scr, 8 tiles each.
// One ROM request in flight at a time, two per tile (left then right half).
// Worst case fits in one line for ready delay <= 2 and response <= 3.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tile_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  gfx_pkg::gfx_cfg_t           cfg,
    input  logic                        fetch_start,
    input  logic [5:0]                  fetch_line,
    input  logic                        rom_ready,
    input  logic                        rom_rsp_valid,
    input  logic [15:0]                 rom_data,
    input  logic [7:0]                  tile_code,
    output logic                        rom_valid,
    output logic [gfx_pkg::rom_aw-1:0]  rom_addr,
    output logic [6:0]                  tile_rd_addr,
    line_wr_if.fetch                    wr
);

    gfx_pkg::fetch_state_t state;
    logic       layer;
    logic [2:0] tile;
    logic       half;
    logic [5:0] line_q;
    logic [7:0] code_q;
    logic [5:0] map_row;

    // Scroll layer is offset vertically, wrapping on the 64 pixel map
    assign map_row      = layer ? line_q + cfg.scroll_y : line_q;
    assign tile_rd_addr = {layer, map_row[5:3], tile};

    assign rom_valid = (state == gfx_pkg::rom_req);
    assign rom_addr  = {code_q, map_row[2:0], half};

    // Response goes straight to the line buffer
    assign wr.we    = (state == gfx_pkg::rom_wait) && rom_rsp_valid;
    assign wr.layer = layer;
    assign wr.x     = {tile, half, 2'b00};
    assign wr.pix   = rom_data;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= gfx_pkg::idle;
            layer <= 1'b0;
            tile  <= 3'd0;
            half  <= 1'b0;
        end else begin
            case (state)
                gfx_pkg::idle: begin
                    if (fetch_start) begin
                        layer <= 1'b0;
                        tile  <= 3'd0;
                        half  <= 1'b0;
                        state <= gfx_pkg::next;
                    end
                end
                // Tile address settles here, code is out of RAM next cycle
                gfx_pkg::next:    state <= gfx_pkg::code_rd;
                gfx_pkg::code_rd: state <= gfx_pkg::rom_req;
                gfx_pkg::rom_req: begin
                    if (rom_ready) begin
                        state <= gfx_pkg::rom_wait;
                    end
                end
                gfx_pkg::rom_wait: begin
                    if (rom_rsp_valid) begin
                        half <= ~half;
                        if (!half) begin
                            state <= gfx_pkg::rom_req;
                        end else if (tile == 3'(gfx_pkg::map_tiles - 1)) begin
                            tile  <= 3'd0;
                            layer <= 1'b1;
                            state <= layer ? gfx_pkg::idle : gfx_pkg::next;
                        end else begin
                            tile  <= tile + 1'b1;
                            state <= gfx_pkg::next;
                        end
                    end
                end
                default: state <= gfx_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == gfx_pkg::idle && fetch_start) begin
            line_q <= fetch_line;
        end
        if (state == gfx_pkg::code_rd) begin
            code_q <= tile_code;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        fetch_start |-> state == gfx_pkg::idle)
        else $error("fetch_start arrived in state %s", state.name());

    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        rom_valid && !rom_ready |=> rom_valid && $stable(rom_addr))
        else $error("ROM request dropped or changed in state %s", state.name());

endmodule

`default_nettype wire

// ==== tilemap/line_buffer.sv ====
// --------------------------------------------------------------------------
// Ping-pong line buffers, two banks per layer, 64 pixels per bank.
// Writes land in the bank of the fetched line's parity, reads use the
// displayed line's parity. Read data appears one cycle after rd_x.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_par,
    input  logic       vcount_par,
    input  logic [5:0] rd_x_chr,
    input  logic [5:0] rd_x_scr,
    line_wr_if.buffer  wr,
    output logic [3:0] chr_pix,
    output logic [3:0] scr_pix
);

    // Address is {layer, bank, column}
    logic [3:0] mem [0:255];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            for (int i = 0; i < 4; i++) begin
                mem[{wr.layer, fetch_par, wr.x[5:2], 2'(i)}] <= wr.pix[15 - 4*i -: 4];
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            chr_pix <= 4'h0;
            scr_pix <= 4'h0;
        end else begin
            chr_pix <= mem[{1'b0, vcount_par, rd_x_chr}];
            scr_pix <= mem[{1'b1, vcount_par, rd_x_scr}];
        end
    end

endmodule

`default_nettype wire

// ==== design/colour_mixer.sv ====
// --------------------------------------------------------------------------
// Layer mixer. chr is fixed, scr scrolls horizontally by scroll_x.
// Output lags the active strobe by two cycles, without back-pressure.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module colour_mixer #(
    parameter int h_active = gfx_pkg::h_active
) (
    input  logic                        clk,
    input  logic                        rst,
    input  gfx_pkg::gfx_cfg_t           cfg,
    input  logic [$clog2(h_active)-1:0] hcount,
    input  logic                        active,
    input  logic [3:0]                  chr_pix,
    input  logic [3:0]                  scr_pix,
    output logic [5:0]                  rd_x_chr,
    output logic [5:0]                  rd_x_scr,
    output logic                        pxl_valid,
    output gfx_pkg::pxl_color_t         pxl_color
);

    logic [5:0] col;
    logic       act_q;
    logic [3:0] chr_n;
    logic [3:0] scr_n;

    // Map column wraps at 64 pixels
    assign col      = 6'(hcount);
    assign rd_x_chr = col;
    assign rd_x_scr = col + cfg.scroll_x;

    assign chr_n = cfg.chr_en ? chr_pix : 4'h0;
    assign scr_n = cfg.scr_en ? scr_pix : 4'h0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            act_q     <= 1'b0;
            pxl_valid <= 1'b0;
        end else begin
            act_q     <= active;
            pxl_valid <= act_q;
        end
    end

    // Opaque chr on top, otherwise scr even when transparent
    always_ff @(posedge clk) begin
        pxl_color.pal_bank <= cfg.pal_bank;
        pxl_color.layer    <= (chr_n == 4'h0);
        pxl_color.nibble   <= (chr_n != 4'h0) ? chr_n : scr_n;
    end

endmodule

`default_nettype wire

// ==== design/gfx_top.sv ====
// --------------------------------------------------------------------------
// Two-layer tile graphics block, single clock, one pixel per clock.
// ROM port allows one outstanding request, answered by one response.
// CPU writes are expected during vertical blank.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gfx_top #(
    parameter int h_active = gfx_pkg::h_active,
    parameter int h_total  = gfx_pkg::h_total,
    parameter int v_active = gfx_pkg::v_active,
    parameter int v_total  = gfx_pkg::v_total
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_cs,
    input  logic                       cpu_we,
    input  logic [7:0]                 cpu_addr,
    input  logic [7:0]                 cpu_din,
    output logic                       rom_valid,
    input  logic                       rom_ready,
    output logic [gfx_pkg::rom_aw-1:0] rom_addr,
    input  logic                       rom_rsp_valid,
    input  logic [15:0]                rom_data,
    output logic                       pxl_valid,
    output gfx_pkg::pxl_color_t        pxl_color,
    output logic                       vblank,
    output logic                       irq_n
);

    gfx_pkg::gfx_cfg_t          cfg;
    logic [6:0]                 tile_rd_addr;
    logic [7:0]                 tile_code;
    logic [$clog2(h_total)-1:0] hcount;
    logic [$clog2(v_total)-1:0] vcount;
    logic                       active;
    logic                       fetch_start;
    logic [5:0]                 fetch_line;
    logic                       vblank_start;
    logic [5:0]                 rd_x_chr;
    logic [5:0]                 rd_x_scr;
    logic [3:0]                 chr_pix;
    logic [3:0]                 scr_pix;

    line_wr_if u_wr ();

    gfx_cpu_port u_cpu (
        .clk(clk), .rst(rst), .cpu_cs(cpu_cs), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
        .cpu_din(cpu_din), .vblank_start(vblank_start), .tile_rd_addr(tile_rd_addr),
        .cfg(cfg), .tile_code(tile_code), .irq_n(irq_n)
    );

    scan_timer #(
        .h_active(h_active), .h_total(h_total), .v_active(v_active), .v_total(v_total)
    ) u_timer (
        .clk(clk), .rst(rst), .hcount(hcount), .vcount(vcount), .active(active),
        .fetch_start(fetch_start), .fetch_line(fetch_line), .vblank(vblank),
        .vblank_start(vblank_start)
    );

    tile_fetch u_fetch (
        .clk(clk), .rst(rst), .cfg(cfg), .fetch_start(fetch_start), .fetch_line(fetch_line),
        .rom_ready(rom_ready), .rom_rsp_valid(rom_rsp_valid), .rom_data(rom_data),
        .tile_code(tile_code), .rom_valid(rom_valid), .rom_addr(rom_addr),
        .tile_rd_addr(tile_rd_addr), .wr(u_wr.fetch)
    );

    line_buffer u_lbuf (
        .clk(clk), .rst(rst), .fetch_par(fetch_line[0]), .vcount_par(vcount[0]),
        .rd_x_chr(rd_x_chr), .rd_x_scr(rd_x_scr), .wr(u_wr.buffer),
        .chr_pix(chr_pix), .scr_pix(scr_pix)
    );

    colour_mixer #(.h_active(h_active)) u_mix (
        .clk(clk), .rst(rst), .cfg(cfg), .hcount(hcount[$clog2(h_active)-1:0]),
        .active(active), .chr_pix(chr_pix), .scr_pix(scr_pix), .rd_x_chr(rd_x_chr),
        .rd_x_scr(rd_x_scr), .pxl_valid(pxl_valid), .pxl_color(pxl_color)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_gfx.sv ====
// --------------------------------------------------------------------------
// Testbench for gfx_top with a reference renderer and a ROM model.
// The ROM model gives random ready delays of 0..2 and response delays of 1..3.
// CPU setup runs early in vblank, before the line 0 fetch starts.
// Stops at the first error.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_gfx;

    localparam int n_pixels     = gfx_pkg::h_active * gfx_pkg::v_active;
    localparam int frame_cycles = gfx_pkg::h_total * gfx_pkg::v_total;

    logic                clk = 1'b0;
    logic                rst;
    logic                cpu_cs;
    logic                cpu_we;
    logic [7:0]          cpu_addr;
    logic [7:0]          cpu_din;
    logic                rom_valid;
    logic                rom_ready;
    logic [11:0]         rom_addr;
    logic                rom_rsp_valid;
    logic [15:0]         rom_data;
    logic                pxl_valid;
    gfx_pkg::pxl_color_t pxl_color;
    logic                vblank;
    logic                irq_n;

    integer            seed = 32'ha0e2;
    logic [15:0]       rom_mem [0:4095];
    logic [7:0]        tile_model [0:127];
    logic [1:0]        ready_dly [0:255];
    logic [1:0]        rsp_dly [0:255];
    gfx_pkg::gfx_cfg_t m_cfg;

    gfx_top dut (.*);

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_color(input string name, input gfx_pkg::pxl_color_t exp,
                               input gfx_pkg::pxl_color_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // One nibble of a layer at a map position
    function automatic logic [3:0] map_nibble(input logic layer, input logic [5:0] col,
                                              input logic [5:0] row);
        logic [7:0]  code;
        logic [15:0] word;
        int          sh;
        code = tile_model[{layer, row[5:3], col[5:3]}];
        word = rom_mem[{code, row[2:0], col[2]}];
        sh   = 12 - 4 * int'(col[1:0]);
        return word[sh +: 4];
    endfunction

    function automatic gfx_pkg::pxl_color_t ref_pixel(input int x, input int y);
        gfx_pkg::pxl_color_t c;
        logic [3:0]          chr;
        logic [3:0]          scr;
        chr = m_cfg.chr_en ? map_nibble(1'b0, 6'(x), 6'(y)) : 4'h0;
        scr = m_cfg.scr_en ?
              map_nibble(1'b1, 6'(x + m_cfg.scroll_x), 6'(y + m_cfg.scroll_y)) : 4'h0;
        c.pal_bank = m_cfg.pal_bank;
        c.layer    = (chr == 4'h0);
        c.nibble   = (chr != 4'h0) ? chr : scr;
        return c;
    endfunction

    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu_cs   <= 1'b1;
        cpu_we   <= 1'b1;
        cpu_addr <= addr;
        cpu_din  <= data;
        if (addr[7]) begin
            tile_model[addr[6:0]] = data;
        end else if (addr == gfx_pkg::reg_scroll_x) begin
            m_cfg.scroll_x = data[5:0];
        end else if (addr == gfx_pkg::reg_scroll_y) begin
            m_cfg.scroll_y = data[5:0];
        end else if (addr == gfx_pkg::reg_ctrl) begin
            m_cfg.chr_en   = data[0];
            m_cfg.scr_en   = data[1];
            m_cfg.irq_en   = data[2];
            m_cfg.pal_bank = data[5:4];
        end
    endtask

    task automatic cpu_release();
        @(posedge clk);
        cpu_cs <= 1'b0;
        cpu_we <= 1'b0;
    endtask

    task automatic setup_frame(input logic [7:0] ctrl, input logic [7:0] sx,
                               input logic [7:0] sy);
        for (int i = 0; i < 128; i++) begin
            cpu_write(8'h80 | 8'(i), 8'($random(seed)));
        end
        cpu_write(gfx_pkg::reg_scroll_x, sx);
        cpu_write(gfx_pkg::reg_scroll_y, sy);
        cpu_write(gfx_pkg::reg_ctrl, ctrl);
        // Unused register address must leave the values just written alone
        cpu_write(8'h05, 8'($random(seed)));
        cpu_release();
    endtask

    task automatic wait_vblank(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (vblank !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > frame_cycles) begin
                $display("Timeout while waiting for %s", what);
                stop_run();
            end
        end
    endtask

    // Call right after vblank falls; pixels arrive in raster order
    task automatic check_frame(input string name);
        int count;
        int cycles;
        count  = 0;
        cycles = 0;
        while (count < n_pixels) begin
            @(negedge clk);
            cycles++;
            if (cycles > frame_cycles) begin
                $display("Timeout while waiting for pixels of %s", name);
                stop_run();
            end
            if (pxl_valid) begin
                check_bit($sformatf("%s vblank", name), 1'b0, vblank);
                check_color($sformatf("%s x=%0d y=%0d", name, count % gfx_pkg::h_active,
                            count / gfx_pkg::h_active),
                            ref_pixel(count % gfx_pkg::h_active, count / gfx_pkg::h_active),
                            pxl_color);
                count++;
            end
        end
    endtask

    // ROM responder looks at the bus at negedge and drives at posedge
    initial begin : rom_responder
        logic [11:0] req_addr;
        logic [7:0]  idx;
        int          wait_left;
        rom_ready     = 1'b0;
        rom_rsp_valid = 1'b0;
        rom_data      = 16'h0;
        idx           = 8'd0;
        wait_left     = 0;
        forever begin
            @(negedge clk);
            if (rom_valid && rom_ready) begin
                req_addr = rom_addr;
                @(posedge clk);
                rom_ready <= 1'b0;
                repeat (int'(rsp_dly[idx]) - 1) @(posedge clk);
                rom_rsp_valid <= 1'b1;
                rom_data      <= rom_mem[req_addr];
                @(posedge clk);
                rom_rsp_valid <= 1'b0;
                idx       = idx + 1'b1;
                wait_left = ready_dly[idx];
                rom_ready <= (wait_left == 0);
            end else if (rom_valid) begin
                if (wait_left > 0) begin
                    wait_left--;
                end
                if (wait_left == 0) begin
                    @(posedge clk);
                    rom_ready <= 1'b1;
                end
            end
        end
    end

    initial begin : main
        logic [7:0] ctrl;
        int         cycles;
        rst      = 1'b1;
        cpu_cs   = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = 8'h0;
        cpu_din  = 8'h0;
        m_cfg    = '0;
        for (int i = 0; i < 4096; i++) begin
            rom_mem[i] = 16'($random(seed));
        end
        for (int i = 0; i < 256; i++) begin
            ready_dly[i] = 2'($unsigned($random(seed)) % 3);
            rsp_dly[i]   = 2'($unsigned($random(seed)) % 3 + 1);
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_bit("reset_irq_n", 1'b1, irq_n);
        check_bit("reset_rom_valid", 1'b0, rom_valid);
        check_bit("reset_pxl_valid", 1'b0, pxl_valid);
        check_bit("reset_vblank", 1'b0, vblank);
        @(negedge clk);
        check_bit("reset_pxl_valid", 1'b0, pxl_valid);

        wait_vblank(1'b1, "vblank");
        setup_frame(8'h01, 8'h00, 8'h00);
        wait_vblank(1'b0, "frame start");
        check_frame("chr_only");

        wait_vblank(1'b1, "vblank");
        setup_frame(8'h03, 8'($random(seed)), 8'($random(seed)));
        wait_vblank(1'b0, "frame start");
        check_frame("chr_over_scr");

        for (int f = 0; f < 3; f++) begin
            wait_vblank(1'b1, "vblank");
            ctrl = 8'($random(seed)) & 8'h37;
            setup_frame(ctrl, 8'($random(seed)), 8'($random(seed)));
            wait_vblank(1'b0, "frame start");
            check_frame($sformatf("random_ctrl_%0d", f));
        end

        // Interrupt raised at vblank and released by acknowledge
        wait_vblank(1'b1, "vblank");
        cpu_write(gfx_pkg::reg_irq_ack, 8'h00);
        cpu_write(gfx_pkg::reg_ctrl, 8'h05);
        cpu_release();
        wait_vblank(1'b0, "frame start");
        wait_vblank(1'b1, "vblank");
        check_bit("irq_before_vblank_start", 1'b1, irq_n);
        @(negedge clk);
        check_bit("irq_assert", 1'b0, irq_n);
        cpu_write(gfx_pkg::reg_irq_ack, 8'h00);
        cpu_release();
        @(negedge clk);
        check_bit("irq_ack", 1'b1, irq_n);

        // With irq_en clear the line stays high through a whole vblank
        cpu_write(gfx_pkg::reg_ctrl, 8'h01);
        cpu_release();
        wait_vblank(1'b0, "frame start");
        wait_vblank(1'b1, "vblank");
        cycles = 0;
        while (vblank) begin
            check_bit("irq_disabled", 1'b1, irq_n);
            @(negedge clk);
            cycles++;
            if (cycles > frame_cycles) begin
                $display("Timeout while waiting for vblank to end");
                stop_run();
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/gfx_pkg.sv
common/line_wr_if.sv
design/gfx_cpu_port.sv
design/scan_timer.sv
tilemap/tile_fetch.sv
tilemap/line_buffer.sv
design/colour_mixer.sv
design/gfx_top.sv
testbench/tb_gfx.sv

// ==== run.sh ====
#!/bin/sh
# Compile the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_gfx -f build.f -o tb_gfx

out=$(./obj_dir/tb_gfx 2>&1) || true
printf '%s\n' "$out"

# Pass only when the testbench reported success
printf '%s\n' "$out" | grep -q "No errors"
